// ==== lvdc_timing.f ====
verilog/lvdc_pkg.sv
verilog/phase_gen.sv
verilog/bit_counter.sv
verilog/clock_drivers.sv
verilog/lvdc_timing.sv
tb/tb_lvdc_timing.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
    --top-module tb_lvdc_timing \
    -Mdir obj_dir \
    -f lvdc_timing.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

output=$(./obj_dir/Vtb_lvdc_timing)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "sim passed"; then
    echo "Result: PASS"
    exit 0
else
    echo "Result: FAIL"
    exit 1
fi

// ==== tb/lvdc_tests.txt ====
# cycles run seu_lane | pp qp rp bit_time_o syllable_o word_g w7 y5 after the last cycle (hex)
# seu_lane upsets its lane on the first cycle of the line only, 0 is no upset
# Reset values
1 0 0  1 0 0 0 0 00 0 0
# Phase rotation, one cycle at a time
1 1 0  1 0 0 0 0 00 0 0
1 1 0  0 1 0 0 0 00 0 0
1 1 0  0 0 1 0 0 00 0 0
1 1 0  1 0 0 1 0 00 0 0
# Run low holds phase and counts
5 0 0  0 1 0 1 0 00 0 0
3 0 0  0 1 0 1 0 00 0 0
# Bit time wraps and the syllable toggles
38 1 0  0 0 1 d 0 00 0 0
1 1 0  1 0 0 0 1 00 0 0
# w7 at qp of bit time 7 in syllable 1
22 1 0  0 1 0 7 1 00 1 0
1 1 0  0 0 1 7 1 00 0 0
# First word step after 84 cycles
19 1 0  1 0 0 0 0 01 0 0
# rp of bit time 5 in syllable 0 gives no y5
17 1 0  0 0 1 5 0 01 0 0
# y5 at rp of bit time 5 in syllable 1
42 1 0  0 0 1 5 1 01 0 1
5 1 0  0 1 0 7 1 01 1 0
42 1 0  0 1 0 7 0 03 1 0
1 1 0  0 0 1 7 0 03 0 0
# Upsets into each lane
4 1 1  1 0 0 9 0 03 0 0
4 1 2  0 1 0 a 0 03 0 0
4 1 3  0 0 1 b 0 03 0 0
3 0 1  1 0 0 c 0 03 0 0
6 1 2  0 0 1 d 0 03 0 0
3 1 3  0 0 1 0 1 03 0 0
# Long runs through several Gray steps of the word count
239 1 0  0 1 0 a 0 07 0 0
230 1 0  1 0 0 3 0 0c 0 0
10069 1 0  0 1 0 d 1 40 0 0
# Word 127 wraps to 0
4 1 0  0 0 1 0 0 00 0 0
2 0 0  1 0 0 1 0 00 0 0
5 1 1  0 1 0 2 0 00 0 0
4 0 0  0 0 1 2 0 00 0 0
1 1 0  0 0 1 2 0 00 0 0
1 1 0  1 0 0 3 0 00 0 0

// ==== tb/tb_lvdc_timing.sv ====
`timescale 1ns/1ns

module tb_lvdc_timing
    import lvdc_pkg::*;
();

    logic              clk;
    logic              rst;
    logic              run;
    logic [1:0]        seu_lane;
    logic              pp;
    logic              qp;
    logic              rp;
    logic [bit_w-1:0]  bit_time_o;
    logic              syllable_o;
    logic [word_w-1:0] word_g;
    logic              w7;
    logic              y5;
    logic              tmr_err;

    int         t_cycles [$];
    logic       t_run    [$];
    logic [1:0] t_seu    [$];
    logic [7:0] t_expect [$]; // Eight expected outputs per test

    string sig_names [8] = '{"pp", "qp", "rp", "bit_time_o", "syllable_o", "word_g", "w7", "y5"};

    int num_tests    = 0;
    int tests_done   = 0;
    int checks       = 0;
    int errors       = 0;
    int cycle_limit  = 0;
    bit tests_loaded = 1'b0;

    lvdc_timing lvdc_timing_i (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .seu_lane   (seu_lane),
        .pp         (pp),
        .qp         (qp),
        .rp         (rp),
        .bit_time_o (bit_time_o),
        .syllable_o (syllable_o),
        .word_g     (word_g),
        .w7         (w7),
        .y5         (y5),
        .tmr_err    (tmr_err)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic finish_run();
        $display("Tests %0d of %0d, checks %0d, errors %0d", tests_done, num_tests, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    endtask

    task automatic check_signal(input int t, input string name, input logic [7:0] actual,
                                input logic [7:0] expected);
        checks++;
        assert (actual === expected) else begin
            $display("FAILED %s in test %0d expected 0x%h actual 0x%h",
                     name, t + 1, expected, actual);
            errors++;
        end
    endtask

    function automatic logic [7:0] actual_value(input int idx);
        logic [7:0] v;
        case (idx)
            0:       v = {7'd0, pp};
            1:       v = {7'd0, qp};
            2:       v = {7'd0, rp};
            3:       v = 8'(bit_time_o);
            4:       v = {7'd0, syllable_o};
            5:       v = 8'(word_g);
            6:       v = {7'd0, w7};
            default: v = {7'd0, y5};
        endcase
        return v;
    endfunction

    // While reset is held only pp is set and every count and strobe is clear
    task automatic check_reset_values();
        for (int k = 0; k < 8; k++) begin
            check_signal(-1, sig_names[k], actual_value(k), (k == 0) ? 8'h01 : 8'h00);
        end
        check_signal(-1, "tmr_err", {7'd0, tmr_err}, 8'h00);
    endtask

    // Each line holds cycles, run, seu_lane and the eight outputs seen after the last cycle
    task automatic load_tests();
        int    fd;
        int    n;
        int    total;
        int    f [11];
        string line;
        total = 0;
        fd = $fopen("tb/lvdc_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the test file tb/lvdc_tests.txt");
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 0 && line[0] != "#") begin
                    n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                                f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
                    if (n == 11) begin
                        t_cycles.push_back(f[0]);
                        t_run.push_back(f[1][0]);
                        t_seu.push_back(f[2][1:0]);
                        for (int k = 0; k < 8; k++) begin
                            t_expect.push_back(f[k + 3][7:0]);
                        end
                        total += f[0];
                        num_tests++;
                    end else if (n > 0) begin
                        $display("Test file line %0d is incomplete and was skipped", num_tests + 1);
                        errors++;
                    end
                end
            end
            $fclose(fd);
            if (num_tests == 0) begin
                $display("The test file holds no tests");
                errors++;
            end
            cycle_limit = total + 100;
            tests_loaded = 1'b1;
        end
    endtask

    task automatic run_test(input int t);
        logic exp_err;
        run      = t_run[t];
        seu_lane = t_seu[t];
        for (int c = 0; c < t_cycles[t]; c++) begin
            @(posedge clk);
            @(negedge clk);
            exp_err = (c == 0) && (t_seu[t] != 2'd0); // Only the cycle after the upset
            check_signal(t, "tmr_err", {7'd0, tmr_err}, {7'd0, exp_err});
            seu_lane = 2'd0;
        end
        for (int k = 0; k < 8; k++) begin
            check_signal(t, sig_names[k], actual_value(k), t_expect[t * 8 + k]);
        end
        tests_done++;
    endtask

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        wait (tests_loaded);
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d clock cycles with %0d of %0d tests done",
                 cycle_count, tests_done, num_tests);
        errors++;
        finish_run();
    end

    initial begin : main
        rst      = 1'b1;
        run      = 1'b0;
        seu_lane = 2'd0;
        load_tests();
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_reset_values();
        rst = 1'b0;
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        finish_run();
    end

endmodule

// ==== verilog/lvdc_timing.sv ====
`timescale 1ns/1ns

module lvdc_timing
    import lvdc_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              run,
    input  logic [1:0]        seu_lane,
    output logic              pp,
    output logic              qp,
    output logic              rp,
    output logic [bit_w-1:0]  bit_time_o,
    output logic              syllable_o,
    output logic [word_w-1:0] word_g,
    output logic              w7,
    output logic              y5,
    output logic              tmr_err
);

    logic [2:0]        phase;
    logic [bit_w-1:0]  bit_time;
    logic              syllable;
    logic [word_w-1:0] word;

    phase_gen phase_gen_i (
        .clk   (clk),
        .rst   (rst),
        .run   (run),
        .phase (phase)
    );

    bit_counter bit_counter_i (
        .clk      (clk),
        .rst      (rst),
        .run      (run),
        .phase    (phase),
        .seu_lane (seu_lane),
        .bit_time (bit_time),
        .syllable (syllable),
        .word     (word),
        .tmr_err  (tmr_err)
    );

    clock_drivers clock_drivers_i (
        .clk        (clk),
        .rst        (rst),
        .phase      (phase),
        .bit_time   (bit_time),
        .syllable   (syllable),
        .word       (word),
        .pp         (pp),
        .qp         (qp),
        .rp         (rp),
        .bit_time_o (bit_time_o),
        .syllable_o (syllable_o),
        .word_g     (word_g),
        .w7         (w7),
        .y5         (y5)
    );

endmodule

// ==== verilog/clock_drivers.sv ====
`timescale 1ns/1ns

module clock_drivers
    import lvdc_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic [2:0]        phase,
    input  logic [bit_w-1:0]  bit_time,
    input  logic              syllable,
    input  logic [word_w-1:0] word,
    output logic              pp,
    output logic              qp,
    output logic              rp,
    output logic [bit_w-1:0]  bit_time_o,
    output logic              syllable_o,
    output logic [word_w-1:0] word_g,
    output logic              w7,
    output logic              y5
);

    logic [word_w-1:0] word_gray;

    assign word_gray = word ^ (word >> 1); // Adjacent words differ in one line

    // One aligned output stage for the phase lines and the counts
    always_ff @(posedge clk) begin
        if (rst) begin
            pp         <= 1'b1;
            qp         <= 1'b0;
            rp         <= 1'b0;
            bit_time_o <= '0;
            syllable_o <= 1'b0;
            word_g     <= '0;
        end else begin
            pp         <= (phase == phase_pp);
            qp         <= (phase == phase_qp);
            rp         <= (phase == phase_rp);
            bit_time_o <= bit_time;
            syllable_o <= syllable;
            word_g     <= word_gray;
        end
    end

    // Strobes come from the registered state so they line up with the phase lines
    assign w7 = qp && (bit_time_o == bit_w'(strobe_w_bit));
    assign y5 = rp && syllable_o && (bit_time_o == bit_w'(strobe_y_bit));

    // The strobes fall in different phases and never overlap
    a_strobe_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(w7 && y5)
    );

endmodule

// ==== verilog/bit_counter.sv ====
`timescale 1ns/1ns

module bit_counter
    import lvdc_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              run,
    input  logic [2:0]        phase,
    input  logic [1:0]        seu_lane,
    output logic [bit_w-1:0]  bit_time,
    output logic              syllable,
    output logic [word_w-1:0] word,
    output logic              tmr_err
);

    logic [bit_w-1:0]  bt_lane   [lanes];
    logic              syl_lane  [lanes];
    logic [word_w-1:0] word_lane [lanes];

    logic              advance;
    logic              bt_wrap;
    logic [bit_w-1:0]  bt_next;
    logic              syl_next;
    logic [word_w-1:0] word_next;

    // Bitwise two-out-of-three vote on every field
    assign bit_time = (bt_lane[0] & bt_lane[1]) | (bt_lane[0] & bt_lane[2]) |
                      (bt_lane[1] & bt_lane[2]);
    assign syllable = (syl_lane[0] & syl_lane[1]) | (syl_lane[0] & syl_lane[2]) |
                      (syl_lane[1] & syl_lane[2]);
    assign word     = (word_lane[0] & word_lane[1]) | (word_lane[0] & word_lane[2]) |
                      (word_lane[1] & word_lane[2]);

    // Any lane that disagrees with another one flags an upset
    assign tmr_err = (bt_lane[0] != bt_lane[1]) || (bt_lane[1] != bt_lane[2]) ||
                     (syl_lane[0] != syl_lane[1]) || (syl_lane[1] != syl_lane[2]) ||
                     (word_lane[0] != word_lane[1]) || (word_lane[1] != word_lane[2]);

    assign advance = run && (phase == phase_rp); // Counts step at the end of rp

    // Next state is always derived from the voted value
    always_comb begin
        bt_wrap   = (bit_time == bit_w'(bit_times - 1));
        bt_next   = bit_time;
        syl_next  = syllable;
        word_next = word;
        if (advance) begin
            bt_next = bt_wrap ? '0 : bit_time + 1'b1;
            if (bt_wrap) begin
                syl_next = ~syllable;
                if (syllable) begin
                    word_next = word + 1'b1; // Wraps modulo 128
                end
            end
        end
    end

    for (genvar i = 0; i < lanes; i++) begin : g_lane
        logic inj;

        assign inj = (seu_lane == 2'(i + 1));

        // Loading the voted value every edge scrubs a lane that was hit
        always_ff @(posedge clk) begin
            if (rst) begin
                bt_lane[i]   <= '0;
                syl_lane[i]  <= 1'b0;
                word_lane[i] <= '0;
            end else begin
                bt_lane[i]   <= bt_next ^ {{(bit_w - 1){1'b0}}, inj};
                syl_lane[i]  <= syl_next;
                word_lane[i] <= word_next;
            end
        end
    end

    // The voted bit time stays inside the syllable
    a_bit_range: assert property (
        @(posedge clk) disable iff (rst)
        bit_time <= bit_w'(bit_times - 1)
    );

    // A single upset is scrubbed on the following edge
    a_err_pulse: assert property (
        @(posedge clk) disable iff (rst)
        tmr_err |=> !tmr_err
    );

endmodule

// ==== verilog/phase_gen.sv ====
`timescale 1ns/1ns

module phase_gen
    import lvdc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       run,
    output logic [2:0] phase
);

    logic [2:0] phase_next;

    always_comb begin
        case (phase)
            phase_pp: phase_next = phase_qp;
            phase_qp: phase_next = phase_rp;
            phase_rp: phase_next = phase_pp;
            default:  phase_next = phase_pp; // Recover from an illegal code
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= phase_pp;
        end else if (run) begin
            phase <= phase_next; // Holds while run is low
        end
    end

    // Exactly one phase line is active at all times
    a_phase_onehot: assert property (
        @(posedge clk) disable iff (rst)
        $onehot(phase)
    );

endmodule

// ==== verilog/lvdc_pkg.sv ====
package lvdc_pkg;

    // One-hot phase codes, rotated pp then qp then rp
    localparam logic [2:0] phase_pp = 3'b001;
    localparam logic [2:0] phase_qp = 3'b010;
    localparam logic [2:0] phase_rp = 3'b100;

    // Bit times in one syllable
    localparam int bit_times = 14;

    // Counter field widths
    localparam int bit_w  = 4;
    localparam int word_w = 7;

    // Bit times that carry the two decoded strobes
    localparam int strobe_w_bit = 7;
    localparam int strobe_y_bit = 5;

    // Redundant counter lanes behind the majority voter
    localparam int lanes = 3;

endpackage
